// File: src/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// Program counter
`define PC_WD            32

// Raw instruction word
`define INST_WD          32

// Instruction memory port
`define SRAM_ADDR_WD     32
`define SRAM_DATA_WD     32

// PC held in reset, first request lands on address 0
`define RESET_PC_VALUE   32'hfffffffc

// ------------------------------
// Stage-to-stage buses
// ------------------------------

// Taken bit plus target
`define BR_BUS_WD        33

// Instruction plus its PC
`define FS_TO_DS_BUS_WD  64

// ALU op (2), src1 (32), src2 (32), rd (5), write enable (1), PC (32)
`define DS_TO_ES_BUS_WD  104

`endif

// File: src/cpu_types_pkg.sv
`include "cpu_defs.svh"

package cpu_types_pkg;

    // Instruction address
    typedef logic [`PC_WD-1:0] pc_t;

    // Raw instruction as read from memory
    typedef logic [`INST_WD-1:0] inst_t;

    // Register value, RV32 so always 32 bits
    typedef logic [31:0] word_t;

    // Register number, x0 to x31
    typedef logic [4:0] reg_idx_t;

endpackage

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    // ------------------------------
    // Major opcodes, bits 6:0
    // ------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // ------------------------------
    // ALU operations
    // ------------------------------
    typedef enum logic [1:0] {
        ALU_ADD    = 2'd0,
        ALU_SUB    = 2'd1,
        ALU_PASS_B = 2'd2
    } alu_op_e;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 values, SUB differs only in bit 30
    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetch_stage import cpu_types_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ds_allowin,
    input  logic [`BR_BUS_WD-1:0]        br_bus,
    input  word_t                        inst_rdata,
    output logic                         fs_to_ds_valid,
    output logic [`FS_TO_DS_BUS_WD-1:0]  fs_to_ds_bus,
    output logic                         inst_en,
    output pc_t                          inst_addr
);

    logic  fs_valid;
    logic  fs_ready_go;
    logic  fs_allowin;
    logic  to_fs_valid;
    pc_t   fs_pc;
    pc_t   seq_pc;
    pc_t   nextpc;
    logic  br_taken;
    pc_t   br_target;
    inst_t fs_inst;

    // Branch bus from decode
    assign {br_taken, br_target} = br_bus;

    // ------------------------------
    // Pre-IF, next PC selection
    // ------------------------------
    assign to_fs_valid = !reset;
    assign seq_pc      = fs_pc + 32'd4;
    // Redirect wins over sequential
    assign nextpc      = br_taken ? br_target : seq_pc;

    // Request goes out this cycle, data back next cycle
    assign inst_en   = to_fs_valid && fs_allowin;
    assign inst_addr = nextpc;

    // ------------------------------
    // IF stage
    // ------------------------------
    // Memory never stalls here
    assign fs_ready_go = 1'b1;
    assign fs_allowin  = !fs_valid || (fs_ready_go && ds_allowin);
    // Wrong-path word is dropped when decode redirects
    assign fs_to_ds_valid = fs_valid && fs_ready_go && !br_taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= to_fs_valid;
        end
    end

    // PC of the word currently held in IF
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= `RESET_PC_VALUE;
        end else if (to_fs_valid && fs_allowin) begin
            fs_pc <= nextpc;
        end
    end

    assign fs_inst      = inst_rdata[`INST_WD-1:0];
    assign fs_to_ds_bus = {fs_inst, fs_pc};

endmodule

// File: src/decode_stage.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module decode_stage import cpu_types_pkg::*, rv_isa_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         fs_to_ds_valid,
    input  logic [`FS_TO_DS_BUS_WD-1:0]  fs_to_ds_bus,
    input  logic                         es_allowin,
    input  logic                         es_fwd_valid,
    input  reg_idx_t                     es_fwd_rd,
    input  word_t                        es_fwd_data,
    input  word_t                        rs1_data,
    input  word_t                        rs2_data,
    output logic                         ds_allowin,
    output logic [`BR_BUS_WD-1:0]        br_bus,
    output logic                         ds_to_es_valid,
    output logic [`DS_TO_ES_BUS_WD-1:0]  ds_to_es_bus,
    output reg_idx_t                     rs1_addr,
    output reg_idx_t                     rs2_addr
);

    logic                         ds_valid;
    logic                         ds_ready_go;
    logic [`FS_TO_DS_BUS_WD-1:0]  fs_to_ds_bus_r;
    inst_t                        ds_inst;
    pc_t                          ds_pc;
    logic [6:0]                   opcode;
    logic [2:0]                   funct3;
    logic [6:0]                   funct7;
    reg_idx_t                     rd;
    word_t                        imm_i;
    word_t                        imm_u;
    word_t                        imm_b;
    word_t                        imm_j;
    word_t                        rs1_val;
    word_t                        rs2_val;
    alu_op_e                      alu_op;
    word_t                        src1;
    word_t                        src2;
    logic                         writes_rd;
    logic                         ds_we;
    logic                         taken;
    pc_t                          target;

    // ------------------------------
    // Pipeline control
    // ------------------------------
    assign ds_ready_go    = 1'b1;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // Instruction word and PC held in decode
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_to_ds_bus_r <= fs_to_ds_bus;
        end
    end

    assign {ds_inst, ds_pc} = fs_to_ds_bus_r;

    // ------------------------------
    // Field and immediate decode
    // ------------------------------
    assign opcode   = ds_inst[6:0];
    assign rd       = ds_inst[11:7];
    assign funct3   = ds_inst[14:12];
    assign rs1_addr = ds_inst[19:15];
    assign rs2_addr = ds_inst[24:20];
    assign funct7   = ds_inst[31:25];

    assign imm_i = {{20{ds_inst[31]}}, ds_inst[31:20]};
    assign imm_u = {ds_inst[31:12], 12'b0};
    // B and J offsets are scrambled with the lsb fixed at 0
    assign imm_b = {{19{ds_inst[31]}}, ds_inst[31], ds_inst[7],
                    ds_inst[30:25], ds_inst[11:8], 1'b0};
    assign imm_j = {{11{ds_inst[31]}}, ds_inst[31], ds_inst[19:12],
                    ds_inst[20], ds_inst[30:21], 1'b0};

    // Bypass the result that execute writes at the next edge
    assign rs1_val = (es_fwd_valid && es_fwd_rd != '0 && es_fwd_rd == rs1_addr) ?
                     es_fwd_data : rs1_data;
    assign rs2_val = (es_fwd_valid && es_fwd_rd != '0 && es_fwd_rd == rs2_addr) ?
                     es_fwd_data : rs2_data;

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        alu_op    = ALU_ADD;
        src1      = rs1_val;
        src2      = rs2_val;
        writes_rd = 1'b0;
        taken     = 1'b0;
        target    = ds_pc + imm_b;
        case (opcode)
            OP: begin
                if (funct3 == F3_ADD_SUB && funct7 == F7_ADD) begin
                    writes_rd = 1'b1;
                end else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) begin
                    alu_op    = ALU_SUB;
                    writes_rd = 1'b1;
                end
            end
            OP_IMM: begin
                // ADDI only
                src2      = imm_i;
                writes_rd = (funct3 == F3_ADD_SUB);
            end
            LUI: begin
                alu_op    = ALU_PASS_B;
                src2      = imm_u;
                writes_rd = 1'b1;
            end
            BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    taken = (rs1_val == rs2_val);
                end else if (funct3 == F3_BNE) begin
                    taken = (rs1_val != rs2_val);
                end
            end
            JAL: begin
                // Link value rides through the ALU as operand b
                alu_op    = ALU_PASS_B;
                src2      = ds_pc + 32'd4;
                writes_rd = 1'b1;
                taken     = 1'b1;
                target    = ds_pc + imm_j;
            end
            default: begin
                // Unsupported encodings retire as no-ops
                writes_rd = 1'b0;
            end
        endcase
    end

    // rd of x0 counts as no write
    assign ds_we = writes_rd && (rd != '0);

    // Only a live instruction may redirect fetch
    assign br_bus = {ds_valid && taken, target};

    assign ds_to_es_bus = {alu_op, src1, src2, rd, ds_we, ds_pc};

    // A redirect always drops the word fetched behind it
    assert property (@(posedge clk) disable iff (reset)
        br_bus[`BR_BUS_WD-1] |-> !fs_to_ds_valid);

endmodule

// File: src/reg_file.sv
`timescale 1ns/100ps

module reg_file import cpu_types_pkg::*; (
    input  logic     clk,
    input  reg_idx_t rs1_addr,
    input  reg_idx_t rs2_addr,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [32];

    // Synchronous write that never stores x0
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous reads with x0 hardwired to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Execute never sends a write for x0
    assert property (@(posedge clk) we |-> (waddr != '0));

endmodule

// File: src/execute_stage.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module execute_stage import cpu_types_pkg::*, rv_isa_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ds_to_es_valid,
    input  logic [`DS_TO_ES_BUS_WD-1:0]  ds_to_es_bus,
    output logic                         es_allowin,
    output logic                         es_fwd_valid,
    output reg_idx_t                     es_fwd_rd,
    output word_t                        es_fwd_data,
    output logic                         rf_we,
    output reg_idx_t                     rf_waddr,
    output word_t                        rf_wdata,
    output logic                         wb_valid,
    output pc_t                          wb_pc,
    output reg_idx_t                     wb_rd,
    output word_t                        wb_data
);

    logic                         es_valid;
    logic                         es_ready_go;
    logic [`DS_TO_ES_BUS_WD-1:0]  ds_to_es_bus_r;
    logic [1:0]                   alu_op_bits;
    alu_op_e                      es_alu_op;
    word_t                        es_src1;
    word_t                        es_src2;
    reg_idx_t                     es_rd;
    logic                         es_we;
    pc_t                          es_pc;
    word_t                        es_result;

    // Last stage drains every cycle
    assign es_ready_go = 1'b1;
    assign es_allowin  = !es_valid || es_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            ds_to_es_bus_r <= ds_to_es_bus;
        end
    end

    assign {alu_op_bits, es_src1, es_src2, es_rd, es_we, es_pc} = ds_to_es_bus_r;
    assign es_alu_op = alu_op_e'(alu_op_bits);

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (es_alu_op)
            ALU_SUB:    es_result = es_src1 - es_src2;
            ALU_PASS_B: es_result = es_src2;
            default:    es_result = es_src1 + es_src2;
        endcase
    end

    // Write-back and bypass share the same result
    assign rf_we        = es_valid && es_we;
    assign rf_waddr     = es_rd;
    assign rf_wdata     = es_result;
    assign es_fwd_valid = rf_we;
    assign es_fwd_rd    = es_rd;
    assign es_fwd_data  = es_result;

    // Retire report with rd and data zeroed when nothing is written
    assign wb_valid = es_valid && es_ready_go;
    assign wb_pc    = es_pc;
    assign wb_rd    = es_we ? es_rd : '0;
    assign wb_data  = es_we ? es_result : '0;

    // Decode only ever sends the three defined ALU operations
    assert property (@(posedge clk) disable iff (reset)
        es_valid |-> (es_alu_op inside {ALU_ADD, ALU_SUB, ALU_PASS_B}));

endmodule

// File: src/mini_core.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module mini_core import cpu_types_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    output logic                      inst_en,
    output logic [`SRAM_ADDR_WD-1:0]  inst_addr,
    input  logic [`SRAM_DATA_WD-1:0]  inst_rdata,
    output logic                      wb_valid,
    output pc_t                       wb_pc,
    output reg_idx_t                  wb_rd,
    output word_t                     wb_data
);

    // ------------------------------
    // Inter-stage wires
    // ------------------------------
    logic                         ds_allowin;
    logic                         es_allowin;
    logic [`BR_BUS_WD-1:0]        br_bus;
    logic                         fs_to_ds_valid;
    logic [`FS_TO_DS_BUS_WD-1:0]  fs_to_ds_bus;
    logic                         ds_to_es_valid;
    logic [`DS_TO_ES_BUS_WD-1:0]  ds_to_es_bus;
    logic                         es_fwd_valid;
    reg_idx_t                     es_fwd_rd;
    word_t                        es_fwd_data;
    reg_idx_t                     rs1_addr;
    reg_idx_t                     rs2_addr;
    word_t                        rs1_data;
    word_t                        rs2_data;
    logic                         rf_we;
    reg_idx_t                     rf_waddr;
    word_t                        rf_wdata;

    fetch_stage fetch_stage_i (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .inst_rdata     (inst_rdata),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .inst_en        (inst_en),
        .inst_addr      (inst_addr)
    );

    decode_stage decode_stage_i (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .es_fwd_valid   (es_fwd_valid),
        .es_fwd_rd      (es_fwd_rd),
        .es_fwd_data    (es_fwd_data),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_stage execute_stage_i (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .es_fwd_valid   (es_fwd_valid),
        .es_fwd_rd      (es_fwd_rd),
        .es_fwd_data    (es_fwd_data),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .wb_valid       (wb_valid),
        .wb_pc          (wb_pc),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset over two rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: testbench/mini_core_tb.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module mini_core_tb import cpu_types_pkg::*; ();

    // ------------------------------
    // Program layout in word indices
    // ------------------------------
    localparam int T3_START = 7;
    localparam int T4_START = 13;
    localparam int T5_START = 22;
    localparam int T6_START = 28;
    localparam int END_WORD = 48;
    localparam logic [31:0] SELF_LOOP = 32'h0000006f;

    logic                      clk;
    logic                      reset;
    logic                      inst_en;
    logic [`SRAM_ADDR_WD-1:0]  inst_addr;
    logic [`SRAM_DATA_WD-1:0]  inst_rdata;
    logic                      wb_valid;
    pc_t                       wb_pc;
    reg_idx_t                  wb_rd;
    word_t                     wb_data;

    word_t       imem [64];
    logic [31:0] exp_pc[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];
    int          exp_sec[$];
    int          exp_count;
    int          check_idx = 0;
    int          test_errors [1:6];
    logic        reset_done = 1'b0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    clock_gen clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    mini_core dut_i (
        .clk        (clk),
        .reset      (reset),
        .inst_en    (inst_en),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] make_addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] make_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // funct3 0 is BEQ, 1 is BNE
    function automatic logic [31:0] make_branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                                input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] make_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Test number from the PC of a retired instruction
    function automatic int section_of(input logic [31:0] pc);
        if (pc[31:2] < T3_START) return 2;
        if (pc[31:2] < T4_START) return 3;
        if (pc[31:2] < T5_START) return 4;
        if (pc[31:2] < T6_START) return 5;
        return 6;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "reset";
            2: return "dependent arithmetic";
            3: return "x0 and LUI";
            4: return "branches";
            5: return "JAL";
            default: return "random block";
        endcase
    endfunction

    // ------------------------------
    // Program image
    // ------------------------------
    function automatic void load_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          seed;
        seed = 32'h1b69;
        // Unused words hold a custom-0 opcode tagged with their own index
        for (int i = 0; i < 64; i++) begin
            imem[i] = {19'h5a5a, i[5:0], 7'b0001011};
        end
        // Chain where each result feeds the next
        imem[0] = make_addi(5'd1, 5'd0, 12'd5);
        imem[1] = make_addi(5'd2, 5'd1, 12'd7);
        imem[2] = make_r(7'h00, 5'd3, 5'd2, 5'd1);
        imem[3] = make_r(7'h20, 5'd4, 5'd3, 5'd2);
        imem[4] = make_r(7'h00, 5'd5, 5'd4, 5'd4);
        imem[5] = make_r(7'h20, 5'd6, 5'd5, 5'd1);
        imem[6] = make_addi(5'd7, 5'd6, 12'hffd);
        // x0 writes and upper immediates
        imem[T3_START]     = make_addi(5'd0, 5'd1, 12'd9);
        imem[T3_START + 1] = make_r(7'h00, 5'd8, 5'd0, 5'd0);
        imem[T3_START + 2] = make_lui(5'd9, 20'h12345);
        imem[T3_START + 3] = make_addi(5'd10, 5'd9, 12'h678);
        imem[T3_START + 4] = make_lui(5'd0, 20'habcde);
        imem[T3_START + 5] = make_r(7'h00, 5'd11, 5'd0, 5'd9);
        // Taken BEQ, untaken BNE, taken BNE over two, untaken BEQ
        imem[T4_START]     = make_branch(3'b000, 5'd1, 5'd6, 13'd8);
        imem[T4_START + 1] = make_addi(5'd12, 5'd0, 12'd1);
        imem[T4_START + 2] = make_branch(3'b001, 5'd1, 5'd6, 13'd8);
        imem[T4_START + 3] = make_addi(5'd12, 5'd0, 12'd2);
        imem[T4_START + 4] = make_branch(3'b001, 5'd2, 5'd3, 13'd12);
        imem[T4_START + 5] = make_addi(5'd12, 5'd0, 12'd3);
        imem[T4_START + 6] = make_addi(5'd12, 5'd0, 12'd4);
        imem[T4_START + 7] = make_branch(3'b000, 5'd2, 5'd3, 13'd8);
        imem[T4_START + 8] = make_r(7'h00, 5'd13, 5'd12, 5'd12);
        // Link then use it right away
        imem[T5_START]     = make_jal(5'd14, 21'd12);
        imem[T5_START + 1] = make_addi(5'd15, 5'd0, 12'd1);
        imem[T5_START + 2] = make_addi(5'd15, 5'd0, 12'd2);
        imem[T5_START + 3] = make_r(7'h00, 5'd15, 5'd14, 5'd0);
        imem[T5_START + 4] = make_jal(5'd0, 21'd8);
        imem[T5_START + 5] = make_addi(5'd15, 5'd0, 12'd7);
        // Random ALU ops over x1 to x7
        for (int k = 0; k < END_WORD - T6_START; k++) begin
            r   = $random(seed);
            rd  = {2'b00, r[4:2]} % 5'd7 + 5'd1;
            rs1 = {2'b00, r[7:5]} % 5'd7 + 5'd1;
            rs2 = {2'b00, r[10:8]} % 5'd7 + 5'd1;
            case (r[1:0])
                2'd0:    imem[T6_START + k] = make_r(7'h00, rd, rs1, rs2);
                2'd1:    imem[T6_START + k] = make_r(7'h20, rd, rs1, rs2);
                default: imem[T6_START + k] = make_addi(rd, rs1, r[22:11]);
            endcase
        end
        // Park the core
        imem[END_WORD] = make_jal(5'd0, 21'd0);
    endfunction

    // ------------------------------
    // ISA reference
    // ------------------------------
    function automatic void compute_expected();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] off;
        logic [4:0]  rd;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = '0;
        steps = 0;
        while (steps < 200 && imem[pc[7:2]] != SELF_LOOP) begin
            inst    = imem[pc[7:2]];
            rd      = inst[11:7];
            a       = regs[inst[19:15]];
            b       = regs[inst[24:20]];
            next_pc = pc + 32'd4;
            res     = '0;
            wr      = 1'b0;
            case (inst[6:0])
                7'b0110011: begin
                    if (inst[14:12] == 3'b000 && inst[31:25] == 7'h00) begin
                        res = a + b;
                        wr  = 1'b1;
                    end else if (inst[14:12] == 3'b000 && inst[31:25] == 7'h20) begin
                        res = a - b;
                        wr  = 1'b1;
                    end
                end
                7'b0010011: begin
                    res = a + {{20{inst[31]}}, inst[31:20]};
                    wr  = (inst[14:12] == 3'b000);
                end
                7'b0110111: begin
                    res = {inst[31:12], 12'b0};
                    wr  = 1'b1;
                end
                7'b1100011: begin
                    off = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                    if ((inst[14:12] == 3'b000 && a == b) ||
                        (inst[14:12] == 3'b001 && a != b)) begin
                        next_pc = pc + off;
                    end
                end
                7'b1101111: begin
                    off = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                    res     = pc + 32'd4;
                    wr      = 1'b1;
                    next_pc = pc + off;
                end
                default: begin
                end
            endcase
            // x0 is never written and retires as rd 0
            if (rd == 5'd0) begin
                wr = 1'b0;
            end
            if (wr) begin
                regs[rd] = res;
            end
            exp_pc.push_back(pc);
            exp_rd.push_back(wr ? rd : 5'd0);
            exp_data.push_back(wr ? res : 32'd0);
            exp_sec.push_back(section_of(pc));
            pc = next_pc;
            steps++;
        end
    endfunction

    task automatic report_test(input int t);
        if (test_errors[t] == 0) begin
            $display("Test %0d (%s) passed", t, test_name(t));
        end else begin
            $display("Test %0d (%s) failed, %0d errors", t, test_name(t), test_errors[t]);
        end
    endtask

    // ------------------------------
    // Instruction memory model
    // ------------------------------
    always @(posedge clk) begin
        if (inst_en) begin
            inst_rdata <= imem[inst_addr[7:2]];
        end
    end

    // Reset checks start at the second edge since the first only clears the pipeline
    initial begin : reset_check
        @(posedge clk);
        @(posedge clk);
        while (reset) begin
            if (wb_valid !== 1'b0) begin
                $display("Fail at %0t: wb_valid high during reset", $time);
                test_errors[1]++;
            end
            if (inst_en !== 1'b0) begin
                $display("Fail at %0t: inst_en high during reset", $time);
                test_errors[1]++;
            end
            @(posedge clk);
        end
        if (inst_en !== 1'b1 || inst_addr !== 32'd0) begin
            $display("Fail at %0t: first request en %b addr %h, expected 1 and 0",
                     $time, inst_en, inst_addr);
            test_errors[1]++;
        end
        report_test(1);
        reset_done = 1'b1;
    end

    // Retire stream against the reference list
    always @(posedge clk) begin : retire_checker
        int sec;
        if (!reset && wb_valid === 1'b1 && check_idx < exp_count) begin
            sec = exp_sec[check_idx];
            if (wb_pc !== exp_pc[check_idx]) begin
                $display("Fail at %0t: retire %0d pc expected %h, got %h",
                         $time, check_idx, exp_pc[check_idx], wb_pc);
                test_errors[sec]++;
            end
            if (wb_rd !== exp_rd[check_idx]) begin
                $display("Fail at %0t: retire %0d (pc %h) rd expected %0d, got %0d",
                         $time, check_idx, exp_pc[check_idx], exp_rd[check_idx], wb_rd);
                test_errors[sec]++;
            end
            if (wb_data !== exp_data[check_idx]) begin
                $display("Fail at %0t: retire %0d (pc %h) data expected %h, got %h",
                         $time, check_idx, exp_pc[check_idx], exp_data[check_idx], wb_data);
                test_errors[sec]++;
            end
            // Last record of a test closes it
            if (check_idx + 1 == exp_count || exp_sec[check_idx + 1] != sec) begin
                report_test(sec);
            end
            check_idx++;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Error: retire stream stopped, %0d of %0d retirements seen in %0d cycles",
                     check_idx, exp_count, cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin : main_flow
        int passed;
        int failed;
        inst_rdata = '0;
        for (int t = 1; t <= 6; t++) begin
            test_errors[t] = 0;
        end
        load_program();
        compute_expected();
        exp_count   = exp_pc.size();
        // 4 cycles per retirement plus slack for reset and pipeline fill
        cycle_limit = 4 * exp_count + 20;
        wait (reset_done && check_idx == exp_count);
        @(negedge clk);
        passed = 0;
        failed = 0;
        for (int t = 1; t <= 6; t++) begin
            if (test_errors[t] == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end
        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: mini_core.f
+incdir+src
src/cpu_types_pkg.sv
src/rv_isa_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/mini_core.sv
testbench/clock_gen.sv
testbench/mini_core_tb.sv

// File: Bender.yml
package:
  name: mini_core

sources:
  - include_dirs:
      - src
    files:
      - src/cpu_types_pkg.sv
      - src/rv_isa_pkg.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/reg_file.sv
      - src/execute_stage.sv
      - src/mini_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/clock_gen.sv
      - testbench/mini_core_tb.sv
